// File: logic/dct_pkg.sv
package dct_pkg;

	localparam int n_pts = 8;
	localparam int coef_w = 15;
	localparam int frac_bits = 14;
	localparam int row_acc_w = 25;
	localparam int col_acc_w = 32;
	localparam int out_w = 11;

	typedef logic signed [coef_w-1:0] coef_t;
	typedef logic signed [out_w-1:0] dct_val_t;

	// C[k][n] scaled by 2^14, frequency k selects the row and sample n the column
	localparam coef_t coef_table [n_pts][n_pts] = '{
		'{ 5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793},
		'{ 8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035},
		'{ 7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568},
		'{ 6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811},
		'{ 5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793},
		'{ 4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551},
		'{ 3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135},
		'{ 1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598}
	};

	// Mid-scale pixel times eight samples times the DC weight
	function automatic int dc_offset(input int pixel_w);
		return (1 << (pixel_w - 1)) * n_pts * int'(coef_table[0][0]);
	endfunction

	// Bits 24..14 of the sum, plus one when bit 13 is set; the result wraps at 11 bits
	function automatic dct_val_t round_sum(input logic [frac_bits+out_w-1:0] sum);
		logic [out_w-1:0] inc;
		inc = {{(out_w - 1){1'b0}}, sum[frac_bits-1]};
		return $signed(sum[frac_bits +: out_w] + inc);
	endfunction

endpackage

// File: logic/dct_sequencer.sv
`timescale 1ns/1ps

module dct_sequencer (
	input  logic       clk,
	input  logic       rst,
	input  logic       enable,
	output logic [2:0] col_idx,
	output logic [2:0] row_idx,
	output logic       row_start,
	output logic       row_done
);

	logic [2:0] col_cnt;
	logic [2:0] row_cnt;

	// A low enable drops whatever part of the block was seen so far
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			col_cnt <= 3'd0;
			row_cnt <= 3'd0;
		end else begin
			col_cnt <= col_cnt + 3'd1;
			if (col_cnt == 3'd7) begin
				row_cnt <= row_cnt + 3'd1;
			end
		end
	end

	// Counters describe the pixel on data_in in this cycle
	assign col_idx = col_cnt;
	assign row_idx = row_cnt;

	assign row_start = enable && (col_cnt == 3'd0);
	assign row_done = enable && (col_cnt == 3'd7);

endmodule

// File: logic/dct_coef_table.sv
`timescale 1ns/1ps

module dct_coef_table (
	input  logic           clk,
	input  logic [2:0]     col_idx,
	input  logic [2:0]     row_num,
	output dct_pkg::coef_t row_coef [dct_pkg::n_pts],
	output dct_pkg::coef_t col_coef [dct_pkg::n_pts]
);

	// Both lookups pick one table column, all eight frequencies at once
	always_ff @(posedge clk) begin
		for (int k = 0; k < dct_pkg::n_pts; k++) begin
			row_coef[k] <= dct_pkg::coef_table[k][col_idx];
			col_coef[k] <= dct_pkg::coef_table[k][row_num];
		end
	end

endmodule

// File: logic/dct_row_pass.sv
`timescale 1ns/1ps

module dct_row_pass #(
	parameter int pixel_w = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              enable,
	input  logic [pixel_w-1:0] data_in,
	input  dct_pkg::coef_t    row_coef [dct_pkg::n_pts],
	input  logic              row_start,
	input  logic              row_done,
	input  logic [2:0]        row_idx,
	output logic              row_valid,
	output logic [2:0]        row_num,
	output dct_pkg::dct_val_t row_vals [dct_pkg::n_pts]
);

	localparam int n = dct_pkg::n_pts;
	localparam int acc_w = dct_pkg::row_acc_w;
	localparam int coef_w = dct_pkg::coef_w;
	localparam int dc_full = dct_pkg::dc_offset(pixel_w);
	localparam logic signed [acc_w-1:0] dc_off = $signed(dc_full[acc_w-1:0]);

	logic [pixel_w-1:0] pix;
	logic v1;
	logic v2;
	logic start1;
	logic start2;
	logic done1;
	logic done2;
	logic done3;
	logic [2:0] num1;
	logic [2:0] num2;
	logic signed [acc_w-1:0] pix_ext;
	logic signed [acc_w-1:0] coef_ext [n];
	logic signed [acc_w-1:0] prod [n];
	logic signed [acc_w-1:0] acc [n];

	always_ff @(posedge clk) begin
		if (enable) begin
			pix <= data_in;
		end
		num1 <= row_idx;
		num2 <= num1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			start1 <= 1'b0;
			start2 <= 1'b0;
			done1 <= 1'b0;
			done2 <= 1'b0;
			done3 <= 1'b0;
		end else begin
			v1 <= enable;
			v2 <= v1;
			start1 <= row_start;
			start2 <= start1;
			done1 <= row_done;
			done2 <= done1;
			done3 <= done2;
		end
	end

	// Pixels are unsigned, coefficients signed
	always_comb begin
		pix_ext = {{(acc_w - pixel_w){1'b0}}, pix};
		for (int k = 0; k < n; k++) begin
			coef_ext[k] = {{(acc_w - coef_w){row_coef[k][coef_w-1]}}, row_coef[k]};
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < n; k++) begin
			prod[k] <= pix_ext * coef_ext[k];
		end
	end

	// Each row starts a fresh sum on its first product
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < n; k++) begin
				acc[k] <= '0;
			end
		end else if (v2) begin
			for (int k = 0; k < n; k++) begin
				acc[k] <= start2 ? prod[k] : acc[k] + prod[k];
			end
		end
	end

	// row_num settles one cycle before row_valid so the column
	// coefficients are already looked up when the values arrive
	always_ff @(posedge clk) begin
		if (rst) begin
			row_num <= 3'd0;
		end else if (done2) begin
			row_num <= num2;
		end
	end

	// Only frequency 0 carries the mid-scale bias of the pixels
	always_ff @(posedge clk) begin
		if (rst) begin
			row_valid <= 1'b0;
			for (int k = 0; k < n; k++) begin
				row_vals[k] <= '0;
			end
		end else begin
			row_valid <= done3;
			if (done3) begin
				row_vals[0] <= dct_pkg::round_sum(acc[0] - dc_off);
				for (int k = 1; k < n; k++) begin
					row_vals[k] <= dct_pkg::round_sum(acc[k]);
				end
			end
		end
	end

endmodule

// File: logic/dct_col_pass.sv
`timescale 1ns/1ps

module dct_col_pass (
	input  logic              clk,
	input  logic              rst,
	input  logic              row_valid,
	input  logic [2:0]        row_num,
	input  dct_pkg::dct_val_t row_vals [dct_pkg::n_pts],
	input  dct_pkg::coef_t    col_coef [dct_pkg::n_pts],
	output dct_pkg::dct_val_t coef_out [dct_pkg::n_pts*dct_pkg::n_pts],
	output logic              output_enable
);

	localparam int n = dct_pkg::n_pts;
	localparam int acc_w = dct_pkg::col_acc_w;
	localparam int out_w = dct_pkg::out_w;
	localparam int coef_w = dct_pkg::coef_w;
	localparam int rnd_w = dct_pkg::frac_bits + dct_pkg::out_w;

	logic signed [acc_w-1:0] val_ext [n];
	logic signed [acc_w-1:0] coef_ext [n];
	logic signed [acc_w-1:0] prod [n*n];
	logic signed [acc_w-1:0] acc [n*n];
	logic mul_valid;
	logic mul_first;
	logic mul_last;
	logic acc_last;

	always_comb begin
		for (int k = 0; k < n; k++) begin
			val_ext[k] = {{(acc_w - out_w){row_vals[k][out_w-1]}}, row_vals[k]};
			coef_ext[k] = {{(acc_w - coef_w){col_coef[k][coef_w-1]}}, col_coef[k]};
		end
	end

	// Entry i*8+j pairs row frequency i with column frequency j
	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int i = 0; i < n; i++) begin
				for (int j = 0; j < n; j++) begin
					prod[i*n+j] <= val_ext[i] * coef_ext[j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mul_valid <= 1'b0;
			mul_first <= 1'b0;
			mul_last <= 1'b0;
			acc_last <= 1'b0;
		end else begin
			mul_valid <= row_valid;
			mul_first <= (row_num == 3'd0);
			mul_last <= (row_num == 3'(n - 1));
			acc_last <= mul_valid && mul_last;
		end
	end

	// row 0 overwrites, so an aborted block leaves nothing behind
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < n*n; k++) begin
				acc[k] <= '0;
			end
		end else if (mul_valid) begin
			for (int k = 0; k < n*n; k++) begin
				acc[k] <= mul_first ? prod[k] : acc[k] + prod[k];
			end
		end
	end

	// Results hold here until the next complete block
	always_ff @(posedge clk) begin
		if (rst) begin
			output_enable <= 1'b0;
			for (int k = 0; k < n*n; k++) begin
				coef_out[k] <= '0;
			end
		end else begin
			output_enable <= acc_last;
			if (acc_last) begin
				for (int k = 0; k < n*n; k++) begin
					coef_out[k] <= dct_pkg::round_sum(acc[k][rnd_w-1:0]);
				end
			end
		end
	end

endmodule

// File: logic/dct_top.sv
`timescale 1ns/1ps

module dct_top #(
	parameter int pixel_w = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic [pixel_w-1:0] data_in,
	output dct_pkg::dct_val_t  coef_out [dct_pkg::n_pts*dct_pkg::n_pts],
	output logic               output_enable
);

	logic [2:0] col_idx;
	logic [2:0] row_idx;
	logic row_start;
	logic row_done;
	dct_pkg::coef_t row_coef [dct_pkg::n_pts];
	dct_pkg::coef_t col_coef [dct_pkg::n_pts];
	logic row_valid;
	logic [2:0] row_num;
	dct_pkg::dct_val_t row_vals [dct_pkg::n_pts];

	dct_sequencer u_sequencer (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.col_idx   (col_idx),
		.row_idx   (row_idx),
		.row_start (row_start),
		.row_done  (row_done)
	);

	// One table feeds the row multipliers by pixel column and the
	// column multipliers by finished row
	dct_coef_table u_coef_table (
		.clk      (clk),
		.col_idx  (col_idx),
		.row_num  (row_num),
		.row_coef (row_coef),
		.col_coef (col_coef)
	);

	dct_row_pass #(
		.pixel_w (pixel_w)
	) u_row_pass (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.row_coef  (row_coef),
		.row_start (row_start),
		.row_done  (row_done),
		.row_idx   (row_idx),
		.row_valid (row_valid),
		.row_num   (row_num),
		.row_vals  (row_vals)
	);

	dct_col_pass u_col_pass (
		.clk           (clk),
		.rst           (rst),
		.row_valid     (row_valid),
		.row_num       (row_num),
		.row_vals      (row_vals),
		.col_coef      (col_coef),
		.coef_out      (coef_out),
		.output_enable (output_enable)
	);

endmodule

// File: tb/dct_chk.sv
`timescale 1ns/1ps

module dct_chk (
	input logic              clk,
	input logic              rst,
	input logic              output_enable,
	input dct_pkg::dct_val_t coef_out [dct_pkg::n_pts*dct_pkg::n_pts]
);

	localparam int n_out = dct_pkg::n_pts * dct_pkg::n_pts;
	localparam int out_w = dct_pkg::out_w;

	logic [n_out*out_w-1:0] coef_flat;

	always_comb begin
		for (int k = 0; k < n_out; k++) begin
			coef_flat[k*out_w +: out_w] = coef_out[k];
		end
	end

	quiet_in_reset: assert property (@(posedge clk) rst |=> !output_enable)
		else $error("output_enable high while in reset");

	quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !output_enable)
		else $error("output_enable high in the first cycle after reset");

	single_pulse: assert property (@(posedge clk) disable iff (rst)
		output_enable |=> !output_enable)
		else $error("output_enable held high for two cycles");

	// New results may only land together with the pulse
	held_outputs: assert property (@(posedge clk) disable iff (rst)
		!output_enable |-> $stable(coef_flat))
		else $error("coef_out changed without output_enable");

endmodule

bind dct_top dct_chk u_chk (
	.clk           (clk),
	.rst           (rst),
	.output_enable (output_enable),
	.coef_out      (coef_out)
);

// File: tb/dct_model.svh
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

// Keeps the low w bits and reads them back as a signed value
function automatic int wrap_signed(input int v, input int w);
	int s;
	s = 32 - w;
	return (v <<< s) >>> s;
endfunction

// Bits 24..14 plus bit 13, wrapped to 11 bits
function automatic int model_round(input int sum);
	int r;
	r = ((sum >>> 14) + ((sum >>> 13) & 1)) & 2047;
	if (r >= 1024) begin
		r = r - 2048;
	end
	return r;
endfunction

// Row transform first, then columns; entry i*8+j is row frequency i, column frequency j
function automatic void dct_model(input int pix [64], output int coef [64]);
	int rows [8][8];
	int sum;
	for (int r = 0; r < 8; r++) begin
		for (int i = 0; i < 8; i++) begin
			sum = 0;
			for (int n = 0; n < 8; n++) begin
				sum = sum + pix[r*8+n] * int'(dct_pkg::coef_table[i][n]);
			end
			if (i == 0) begin
				sum = sum - dct_pkg::dc_offset(pixel_w);
			end
			rows[r][i] = model_round(wrap_signed(sum, dct_pkg::row_acc_w));
		end
	end
	for (int i = 0; i < 8; i++) begin
		for (int j = 0; j < 8; j++) begin
			sum = 0;
			for (int r = 0; r < 8; r++) begin
				sum = sum + rows[r][i] * int'(dct_pkg::coef_table[j][r]);
			end
			coef[i*8+j] = model_round(wrap_signed(sum, dct_pkg::col_acc_w));
		end
	end
endfunction

`endif

// File: tb/dct_tb.sv
`timescale 1ns/1ps

module dct_tb;

	localparam int pixel_w = 8;
	localparam int n_pix = dct_pkg::n_pts * dct_pkg::n_pts;
	localparam int pulse_timeout = 300;

	logic clk;
	logic rst;
	logic enable;
	logic [pixel_w-1:0] data_in;
	dct_pkg::dct_val_t coef_out [n_pix];
	logic output_enable;

	logic [31:0] lfsr;
	int block_pix [n_pix];
	int model_vals [n_pix];
	int last_vals [n_pix];
	int exp_q [$];
	int pulse_cnt;
	int expect_cnt;
	int abort_len;
	int idle_len;

	`include "dct_model.svh"

	dct_top #(
		.pixel_w (pixel_w)
	) uut (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.coef_out      (coef_out),
		.output_enable (output_enable)
	);

	always #2 clk = ~clk;

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR: time %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic fill_const(input int v);
		for (int k = 0; k < n_pix; k++) begin
			block_pix[k] = v;
		end
	endtask

	task automatic fill_random();
		for (int k = 0; k < n_pix; k++) begin
			block_pix[k] = random_bits(pixel_w);
		end
	endtask

	// Only a complete block queues an expected result
	task automatic send_pixels(input int count);
		for (int k = 0; k < count; k++) begin
			@(negedge clk);
			enable = 1'b1;
			data_in = block_pix[k][pixel_w-1:0];
		end
		if (count == n_pix) begin
			dct_model(block_pix, model_vals);
			for (int k = 0; k < n_pix; k++) begin
				exp_q.push_back(model_vals[k]);
			end
			expect_cnt++;
		end
	endtask

	task automatic idle(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			@(negedge clk);
			enable = 1'b0;
			data_in = '0;
		end
	endtask

	task automatic wait_pulses(input int target);
		int cyc;
		cyc = 0;
		while (pulse_cnt < target) begin
			if (cyc == pulse_timeout) begin
				$display("Timeout waiting for output_enable pulse number %0d", target);
				stop_run();
			end else begin
				@(posedge clk);
				cyc++;
			end
		end
		@(negedge clk);
	endtask

	task automatic check_pulse();
		if (exp_q.size() < n_pix) begin
			$display("output_enable pulsed with no complete block waiting for a result");
			stop_run();
		end else begin
			for (int k = 0; k < n_pix; k++) begin
				last_vals[k] = exp_q.pop_front();
				compare($sformatf("coef_out[%0d]", k), int'(coef_out[k]), last_vals[k]);
			end
			pulse_cnt++;
		end
	endtask

	// Every pulse is checked against the oldest finished block
	always @(negedge clk) begin
		if (!rst && output_enable) begin
			check_pulse();
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		data_in = '0;
		lfsr = 32'h2599_555d;
		pulse_cnt = 0;
		expect_cnt = 0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// Mid-grey cancels against the DC offset everywhere
		fill_const(128);
		send_pixels(n_pix);
		idle(1);
		wait_pulses(expect_cnt);
		for (int k = 0; k < n_pix; k++) begin
			compare($sformatf("coef_out[%0d]", k), int'(coef_out[k]), 0);
		end

		fill_const(255);
		send_pixels(n_pix);
		idle(1);
		wait_pulses(expect_cnt);
		if (coef_out[0] == 0) begin
			$display("DC coefficient of the all-255 block came out zero");
			stop_run();
		end
		for (int k = 1; k < n_pix; k++) begin
			compare($sformatf("coef_out[%0d]", k), int'(coef_out[k]), 0);
		end

		for (int b = 0; b < 20; b++) begin
			fill_random();
			send_pixels(n_pix);
			idle(1 + random_bits(3));
			wait_pulses(expect_cnt);
		end

		// Column tail of one block overlaps the first row of the next
		for (int b = 0; b < 3; b++) begin
			fill_random();
			send_pixels(n_pix);
		end
		idle(1);
		wait_pulses(expect_cnt);

		fill_random();
		abort_len = random_bits(6);
		if (abort_len == 0) begin
			abort_len = 1;
		end
		send_pixels(abort_len);
		idle(1 + random_bits(3));
		fill_random();
		send_pixels(n_pix);
		idle(1);
		wait_pulses(expect_cnt);

		idle_len = 8 + random_bits(5);
		for (int c = 0; c < idle_len; c++) begin
			idle(1);
			for (int k = 0; k < n_pix; k++) begin
				compare($sformatf("coef_out[%0d]", k), int'(coef_out[k]), last_vals[k]);
			end
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: project.f
+incdir+tb
logic/dct_pkg.sv
logic/dct_sequencer.sv
logic/dct_coef_table.sv
logic/dct_row_pass.sv
logic/dct_col_pass.sv
logic/dct_top.sv
tb/dct_chk.sv
tb/dct_tb.sv

// File: Makefile
# Verilator flow for the 8x8 DCT project
VERILATOR ?= verilator
TOP ?= dct_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= Simulation completed successfully
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run passes only when the pass message shows up in its output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
